// ==== hdl/attn_mem_pkg.sv ====
//################################################
// Memory side types for addressing and arbitration
//################################################
`default_nettype none
`include "attn_params.svh"

package attn_mem_pkg;

    typedef logic [$clog2(`MEM_DEPTH)-1:0] addr_t; // Word address

    // Query count, must hold MAX_Q itself
    typedef logic [$clog2(`MAX_Q+1)-1:0] qcount_t;

    // Last holder of the memory grant
    typedef enum logic {
        REQ_Q  = 1'b0,
        REQ_KV = 1'b1
    } requester_t;

endpackage

`default_nettype wire

// ==== hdl/attn_num_pkg.sv ====
//################################################
// Numeric formats for the datapath
// Elements, vectors, products, sums and scores
//################################################
`default_nettype none
`include "attn_params.svh"

package attn_num_pkg;

    // One signed element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // One memory word, element 0 in the low bits
    typedef elem_t [`EMBED_DIM-1:0] vector_t;

    // Full precision element product
    typedef logic signed [2*`ELEM_W-1:0] product_t;

    // Sum of EMBED_DIM products, grown by log2 of the count
    typedef logic signed [2*`ELEM_W+$clog2(`EMBED_DIM)-1:0] dot_t;

    typedef logic signed [`SCORE_W-1:0] score_t; // Saturated output

endpackage

`default_nettype wire

// ==== hdl/attn_params.svh ====
//################################################
// Build-wide sizes for the attention score engine
// Included by packages and by modules that need them
//################################################
`ifndef ATTN_PARAMS_SVH
`define ATTN_PARAMS_SVH

`define EMBED_DIM   4   // Elements per vector
`define SEQ_LEN     4   // K/V rows per query
`define ELEM_W      8   // Signed element width
`define SCORE_W     16  // Signed score width
`define MEM_DEPTH   64  // Vector words in memory
`define SCALE_SHIFT 1   // log2(sqrt(EMBED_DIM))
`define MAX_Q       8   // Largest query count per run

`endif

// ==== hdl/attn_score_top.sv ====
//################################################
// Attention score engine top level
// Host loads memory, pulses start, counts outputs
//################################################
`default_nettype none

module attn_score_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   wr_en,
    input  wire attn_mem_pkg::addr_t    wr_addr,
    input  wire attn_num_pkg::vector_t  wr_data,
    input  wire logic                   start,
    input  wire attn_mem_pkg::addr_t    q_base,
    input  wire attn_mem_pkg::addr_t    k_base,
    input  wire attn_mem_pkg::addr_t    v_base,
    input  wire attn_mem_pkg::qcount_t  num_q,
    output logic                        vld_out,
    input  wire logic                   rdy_in,
    output attn_num_pkg::score_t        score,
    output attn_num_pkg::vector_t       v_out
);

    logic                  rd_en, q_req, q_gnt, q_rvalid, kv_req, kv_gnt, kv_rvalid;
    attn_mem_pkg::addr_t   rd_addr, q_addr, kv_addr;
    attn_num_pkg::vector_t rd_data;                    // Shared by both fetchers
    logic                  q_vld, q_rdy, k_vld, k_rdy, v_vld, v_rdy;
    attn_num_pkg::vector_t q_vec, k_vec, v_vec;

    vec_mem u_mem (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .q_req(q_req), .q_addr(q_addr), .q_rvalid(q_rvalid),
        .kv_req(kv_req), .kv_addr(kv_addr), .kv_rvalid(kv_rvalid),
        .kv_gnt(kv_gnt), .q_gnt(q_gnt), .rd_en(rd_en), .rd_addr(rd_addr),
        .rd_data_valid_src()                           // Observation only
    );

    q_fetch u_qf (
        .clk(clk), .rst(rst), .start(start), .q_base(q_base), .num_q(num_q),
        .req(q_req), .addr(q_addr), .gnt(q_gnt), .rvalid(q_rvalid), .rdata(rd_data),
        .q_vld(q_vld), .q_rdy(q_rdy), .q_out(q_vec)
    );

    kv_fetch u_kvf (
        .clk(clk), .rst(rst), .start(start), .k_base(k_base), .v_base(v_base),
        .num_q(num_q), .req(kv_req), .addr(kv_addr), .gnt(kv_gnt),
        .rvalid(kv_rvalid), .rdata(rd_data),
        .k_vld(k_vld), .k_rdy(k_rdy), .k_out(k_vec),
        .v_vld(v_vld), .v_rdy(v_rdy), .v_out(v_vec)
    );

    dot_product u_dot (
        .clk(clk), .rst(rst),
        .q_vld(q_vld), .q_rdy(q_rdy), .q_in(q_vec),
        .k_vld(k_vld), .k_rdy(k_rdy), .k_in(k_vec),
        .v_vld(v_vld), .v_rdy(v_rdy), .v_in(v_vec),
        .vld_out(vld_out), .rdy_in(rdy_in), .score(score), .v_out(v_out)
    );

endmodule

`default_nettype wire

// ==== hdl/dot_product.sv ====
//################################################
// Scaled dot product of one Q row with SEQ_LEN K rows
// V row leaves alongside its score
//################################################
`default_nettype none
`include "attn_params.svh"

module dot_product (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   q_vld,
    output logic                        q_rdy,
    input  wire attn_num_pkg::vector_t  q_in,
    input  wire logic                   k_vld,
    output logic                        k_rdy,
    input  wire attn_num_pkg::vector_t  k_in,
    input  wire logic                   v_vld,
    output logic                        v_rdy,
    input  wire attn_num_pkg::vector_t  v_in,
    output logic                        vld_out,
    input  wire logic                   rdy_in,   // Downstream ready
    output attn_num_pkg::score_t        score,
    output attn_num_pkg::vector_t       v_out
);

    localparam attn_num_pkg::dot_t SMAX = attn_num_pkg::dot_t'(2**(`SCORE_W-1) - 1);
    localparam attn_num_pkg::dot_t SMIN = attn_num_pkg::dot_t'(-(2**(`SCORE_W-1)));

    attn_num_pkg::vector_t q_r, k_r, v_r;
    logic valid_q, valid_k, valid_v;
    logic [$clog2(`SEQ_LEN)-1:0] row;          // Fires done on the held Q
    logic red_rdy, fire, last;
    attn_num_pkg::product_t [`EMBED_DIM-1:0] prods;
    attn_num_pkg::dot_t sum, scaled;

    assign fire  = valid_q && valid_k && valid_v && red_rdy;
    assign last  = (row == `SEQ_LEN - 1);
    assign q_rdy = !valid_q || (fire && last); // Q freed after the last K/V
    assign k_rdy = !valid_k || fire;
    assign v_rdy = !valid_v || fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            valid_k <= 1'b0;
            valid_v <= 1'b0;
            row     <= '0;
        end else begin
            if (fire) row <= last ? '0 : row + 1'b1;
            if (q_vld && q_rdy)     valid_q <= 1'b1;
            else if (fire && last)  valid_q <= 1'b0;
            if (k_vld && k_rdy)     valid_k <= 1'b1;
            else if (fire)          valid_k <= 1'b0;
            if (v_vld && v_rdy)     valid_v <= 1'b1;
            else if (fire)          valid_v <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (q_vld && q_rdy) q_r <= q_in;
        if (k_vld && k_rdy) k_r <= k_in;
        if (v_vld && v_rdy) v_r <= v_in;
    end

    // Element-wise signed products
    always_comb begin
        for (int i = 0; i < `EMBED_DIM; i++) begin
            prods[i] = attn_num_pkg::product_t'(q_r[i]) * attn_num_pkg::product_t'(k_r[i]);
        end
    end

    tree_reduce #(
        .N     (`EMBED_DIM),
        .TAG_W ($bits(attn_num_pkg::vector_t))
    ) u_tree (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (fire),
        .rdy_out (red_rdy),
        .list_in (prods),
        .tag_in  (v_r),      // V rides as the tag
        .vld_out (vld_out),
        .rdy_in  (rdy_in),
        .sum     (sum),
        .tag_out (v_out)
    );

    // Divide by root of dimension, then clamp
    assign scaled = sum >>> `SCALE_SHIFT;

    always_comb begin
        if (scaled > SMAX)      score = {1'b0, {(`SCORE_W-1){1'b1}}};
        else if (scaled < SMIN) score = {1'b1, {(`SCORE_W-1){1'b0}}};
        else                    score = attn_num_pkg::score_t'(scaled);
    end

endmodule

`default_nettype wire

// ==== hdl/kv_fetch.sv ====
//################################################
// Key/value fetcher, SEQ_LEN K and V rows per query
// K and V each have their own valid/ready slot
//################################################
`default_nettype none
`include "attn_params.svh"

module kv_fetch (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire attn_mem_pkg::addr_t    k_base,
    input  wire attn_mem_pkg::addr_t    v_base,
    input  wire attn_mem_pkg::qcount_t  num_q,
    output logic                        req,
    output attn_mem_pkg::addr_t         addr,
    input  wire logic                   gnt,
    input  wire logic                   rvalid,
    input  wire attn_num_pkg::vector_t  rdata,
    output logic                        k_vld,
    input  wire logic                   k_rdy,
    output attn_num_pkg::vector_t       k_out,
    output logic                        v_vld,
    input  wire logic                   v_rdy,
    output attn_num_pkg::vector_t       v_out
);

    attn_mem_pkg::addr_t         k_base_r;
    attn_mem_pkg::addr_t         v_base_r;
    attn_mem_pkg::qcount_t       q_left;  // Queries whose rows are not all read
    logic [$clog2(`SEQ_LEN)-1:0] row;     // Row within the current query
    logic                        want_v;  // Next read targets the V slot
    logic                        pend;
    logic                        pend_v;  // Outstanding read is a V row
    logic                        idle;
    logic                        last_row;

    assign idle     = (q_left == '0) && !pend && !k_vld && !v_vld;
    assign last_row = (row == `SEQ_LEN - 1);
    assign req      = (q_left != '0) && !pend && (want_v ? !v_vld : !k_vld);
    assign addr     = want_v ? attn_mem_pkg::addr_t'(v_base_r + row)
                             : attn_mem_pkg::addr_t'(k_base_r + row);

    always_ff @(posedge clk) begin
        if (rst) begin
            q_left <= '0;
            row    <= '0;
            want_v <= 1'b0;
            pend   <= 1'b0;
            pend_v <= 1'b0;
            k_vld  <= 1'b0;
            v_vld  <= 1'b0;
        end else begin
            if (start && idle) begin
                q_left <= num_q;
                row    <= '0;
                want_v <= 1'b0;
            end else if (gnt) begin
                pend_v <= want_v;
                want_v <= !want_v; // K then V for each row
                if (want_v) begin
                    row <= last_row ? '0 : row + 1'b1;
                    if (last_row) q_left <= q_left - 1'b1;
                end
            end
            if (gnt)    pend <= 1'b1;
            if (rvalid) pend <= 1'b0;
            if (k_vld && k_rdy)      k_vld <= 1'b0;
            if (v_vld && v_rdy)      v_vld <= 1'b0;
            if (rvalid && !pend_v)   k_vld <= 1'b1;
            if (rvalid && pend_v)    v_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && idle) begin
            k_base_r <= k_base;
            v_base_r <= v_base;
        end
        if (rvalid && !pend_v) k_out <= rdata;
        if (rvalid && pend_v)  v_out <= rdata;
    end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
//################################################
// Round-robin arbiter between the two fetch engines
// Grants combinationally and steers the read-valid
//################################################
`default_nettype none

module mem_arbiter (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 q_req,
    input  wire attn_mem_pkg::addr_t  q_addr,
    output logic                      q_rvalid,
    input  wire logic                 kv_req,
    input  wire attn_mem_pkg::addr_t  kv_addr,
    output logic                      kv_rvalid,
    output logic                      kv_gnt,
    output logic                      q_gnt,
    output logic                      rd_en,             // To vec_mem
    output attn_mem_pkg::addr_t       rd_addr,
    output attn_mem_pkg::requester_t  rd_data_valid_src  // Owner of the read in flight
);

    attn_mem_pkg::requester_t last_gnt; // Also the owner of next cycle's data
    logic                     rd_pend;  // A read was issued last cycle

    // Q wins alone, or when KV was served last
    assign q_gnt   = q_req && (!kv_req || last_gnt == attn_mem_pkg::REQ_KV);
    assign kv_gnt  = kv_req && !q_gnt;
    assign rd_en   = q_req || kv_req;
    assign rd_addr = q_gnt ? q_addr : kv_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_gnt <= attn_mem_pkg::REQ_KV; // Q gets the first tie
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            if (rd_en) begin
                last_gnt <= q_gnt ? attn_mem_pkg::REQ_Q : attn_mem_pkg::REQ_KV;
            end
        end
    end

    // Data fans out, only the valid is steered
    assign q_rvalid          = rd_pend && (last_gnt == attn_mem_pkg::REQ_Q);
    assign kv_rvalid         = rd_pend && (last_gnt == attn_mem_pkg::REQ_KV);
    assign rd_data_valid_src = last_gnt;

endmodule

`default_nettype wire

// ==== hdl/q_fetch.sv ====
//################################################
// Query fetcher reading Q rows in order from memory
// Presents each row on a valid/ready output slot
//################################################
`default_nettype none

module q_fetch (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,   // One-cycle run pulse
    input  wire attn_mem_pkg::addr_t    q_base,
    input  wire attn_mem_pkg::qcount_t  num_q,
    output logic                        req,     // Held until gnt
    output attn_mem_pkg::addr_t         addr,
    input  wire logic                   gnt,
    input  wire logic                   rvalid,
    input  wire attn_num_pkg::vector_t  rdata,
    output logic                        q_vld,
    input  wire logic                   q_rdy,
    output attn_num_pkg::vector_t       q_out
);

    attn_mem_pkg::qcount_t q_left; // Rows still to read
    logic                  pend;   // One read outstanding
    logic                  idle;

    assign idle = (q_left == '0) && !pend && !q_vld;
    assign req  = (q_left != '0) && !pend && !q_vld; // Only into an empty slot

    always_ff @(posedge clk) begin
        if (rst) begin
            q_left <= '0;
            pend   <= 1'b0;
            q_vld  <= 1'b0;
        end else begin
            if (start && idle) begin
                q_left <= num_q;
            end else if (gnt) begin
                q_left <= q_left - 1'b1;
            end
            if (gnt)    pend <= 1'b1;
            if (rvalid) pend <= 1'b0;
            if (q_vld && q_rdy) q_vld <= 1'b0;
            if (rvalid)         q_vld <= 1'b1;
        end
    end

    // Read address and output word
    always_ff @(posedge clk) begin
        if (start && idle) addr <= q_base;
        else if (gnt)      addr <= addr + 1'b1;
        if (rvalid) q_out <= rdata;
    end

endmodule

`default_nettype wire

// ==== hdl/tree_reduce.sv ====
//################################################
// Pipelined adder tree, one register per level
// Elastic valid/ready flow, tag rides with the sum
//################################################
`default_nettype none

module tree_reduce #(
    parameter int N     = 4, // Power of two
    parameter int TAG_W = 32
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            vld_in,
    output logic                                 rdy_out,
    input  wire attn_num_pkg::product_t [N-1:0]  list_in,
    input  wire logic [TAG_W-1:0]                tag_in,
    output logic                                 vld_out,
    input  wire logic                            rdy_in,
    output attn_num_pkg::dot_t                   sum,
    output logic [TAG_W-1:0]                     tag_out
);

    localparam int L = $clog2(N);

    attn_num_pkg::dot_t node [L][N/2]; // Partial sums per level
    logic [TAG_W-1:0]   tag  [L];
    logic               vld  [L];
    logic               rdy  [L+1];   // rdy[l] means level l may load

    assign rdy[L] = rdy_in;

    for (genvar l = 0; l < L; l++) begin : g_lvl
        logic in_vld;

        assign rdy[l]  = !vld[l] || rdy[l+1]; // Empty or advancing
        assign in_vld  = (l == 0) ? vld_in : vld[l-1];

        always_ff @(posedge clk) begin
            if (rst) vld[l] <= 1'b0;
            else if (rdy[l]) vld[l] <= in_vld;
        end

        // Pairwise add into this level
        always_ff @(posedge clk) begin
            if (rdy[l] && in_vld) begin
                for (int i = 0; i < (N >> (l + 1)); i++) begin
                    if (l == 0) begin
                        node[l][i] <= attn_num_pkg::dot_t'(list_in[2*i])
                                    + attn_num_pkg::dot_t'(list_in[2*i+1]);
                    end else begin
                        node[l][i] <= node[l-1][2*i] + node[l-1][2*i+1];
                    end
                end
                tag[l] <= (l == 0) ? tag_in : tag[l-1];
            end
        end
    end

    assign rdy_out = rdy[0];
    assign vld_out = vld[L-1];
    assign sum     = node[L-1][0];
    assign tag_out = tag[L-1];

endmodule

`default_nettype wire

// ==== hdl/vec_mem.sv ====
//################################################
// Vector memory with a host write port and one read port
// Read word appears the cycle after rd_en
//################################################
`default_nettype none
`include "attn_params.svh"

module vec_mem (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_en,   // Host write strobe
    input  wire attn_mem_pkg::addr_t   wr_addr,
    input  wire attn_num_pkg::vector_t wr_data,
    input  wire logic                  rd_en,   // Granted read from arbiter
    input  wire attn_mem_pkg::addr_t   rd_addr,
    output attn_num_pkg::vector_t      rd_data  // Held until next read
);

    attn_num_pkg::vector_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the attention score testbench with Verilator, run it, scan the log
set -u
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f sim.f --top-module tb_attn_score \
    -Mdir obj_dir -o tb_attn_score
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_attn_score > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== sim.f ====
+incdir+hdl
hdl/attn_num_pkg.sv
hdl/attn_mem_pkg.sv
hdl/vec_mem.sv
hdl/mem_arbiter.sv
hdl/q_fetch.sv
hdl/kv_fetch.sv
hdl/tree_reduce.sv
hdl/dot_product.sv
hdl/attn_score_top.sv
tests/tb_attn_score.sv

// ==== tests/tb_attn_score.sv ====
//################################################
// Testbench for the attention score engine
// Loads memory, runs query batches, checks scores
//################################################
`default_nettype none
`include "attn_params.svh"

module tb_attn_score;
    timeunit 1ns;
    timeprecision 100ps;

    // About 56 results, a 70 word load and back-pressure stay far below this
    localparam int TIMEOUT_CYCLES = 4000;

    logic                  clk;
    logic                  rst;
    logic                  wr_en;
    attn_mem_pkg::addr_t   wr_addr;
    attn_num_pkg::vector_t wr_data;
    logic                  start;
    attn_mem_pkg::addr_t   q_base;
    attn_mem_pkg::addr_t   k_base;
    attn_mem_pkg::addr_t   v_base;
    attn_mem_pkg::qcount_t num_q;
    logic                  rdy_in;
    logic                  vld_out;
    attn_num_pkg::score_t  score;
    attn_num_pkg::vector_t v_out;

    attn_num_pkg::vector_t shadow [`MEM_DEPTH]; // Copy of every host write
    int                    exp_score [$];       // Expected results, in order
    attn_num_pkg::vector_t exp_v [$];

    int unsigned lcg_state  = 76920;
    logic        bp_en      = 1'b0;  // Random back-pressure on rdy_in
    int          value_errs = 0;
    int          other_errs = 0;
    int          checks     = 0;
    int          outputs    = 0;
    int          cycles     = 0;

    attn_score_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .start   (start),
        .q_base  (q_base),
        .k_base  (k_base),
        .v_base  (v_base),
        .num_q   (num_q),
        .vld_out (vld_out),
        .rdy_in  (rdy_in),
        .score   (score),
        .v_out   (v_out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper halves of two draws, the low LCG bits repeat too soon
    function automatic attn_num_pkg::vector_t random_vector();
        int unsigned hi;
        int unsigned lo;
        hi = lcg_next() >> 16;
        lo = lcg_next() >> 16;
        return attn_num_pkg::vector_t'((hi << 16) | lo);
    endfunction

    // Dot product, divide by root of dimension, clamp to the score range
    function automatic int ref_score(attn_num_pkg::vector_t q, attn_num_pkg::vector_t k);
        int acc;
        int a;
        int b;
        int smax;
        int smin;
        smax = (1 << (`SCORE_W - 1)) - 1;
        smin = -(1 << (`SCORE_W - 1));
        acc  = 0;
        for (int i = 0; i < `EMBED_DIM; i++) begin
            a    = q[i]; // Signed element, sign extended
            b    = k[i];
            acc += a * b;
        end
        acc = acc >>> `SCALE_SHIFT; // Floor, same as an arithmetic shift
        if (acc > smax) acc = smax;
        if (acc < smin) acc = smin;
        return acc;
    endfunction

    task automatic check_value(input logic signed [63:0] got, input logic signed [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t: %s mismatch, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic write_word(input attn_mem_pkg::addr_t a, input attn_num_pkg::vector_t d);
        @(posedge clk);
        wr_en     <= 1'b1;
        wr_addr   <= a;
        wr_data   <= d;
        shadow[a]  = d;
    endtask

    task automatic end_writes();
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // Queue every expected result, then pulse start
    task automatic run_queries(input attn_mem_pkg::addr_t qb, input attn_mem_pkg::addr_t kb,
                               input attn_mem_pkg::addr_t vb, input attn_mem_pkg::qcount_t nq);
        attn_mem_pkg::addr_t qa;
        attn_mem_pkg::addr_t ka;
        attn_mem_pkg::addr_t va;
        for (int qi = 0; qi < int'(nq); qi++) begin
            qa = attn_mem_pkg::addr_t'(qb + qi);
            for (int j = 0; j < `SEQ_LEN; j++) begin // Query-major, row-minor
                ka = attn_mem_pkg::addr_t'(kb + j);
                va = attn_mem_pkg::addr_t'(vb + j);
                exp_score.push_back(ref_score(shadow[qa], shadow[ka]));
                exp_v.push_back(shadow[va]);
            end
        end
        @(posedge clk);
        start  <= 1'b1;
        q_base <= qb;
        k_base <= kb;
        v_base <= vb;
        num_q  <= nq;
        @(posedge clk);
        start  <= 1'b0;
    endtask

    // Wait for the host's count of outputs, then idle to catch strays
    task automatic wait_drain();
        while (exp_score.size() != 0) @(posedge clk);
        repeat (4 * `SEQ_LEN) @(posedge clk);
    endtask

    // Comparison on every accepted output
    always @(posedge clk) begin
        if (!rst && vld_out && rdy_in) begin
            outputs++;
            if (exp_score.size() == 0) begin
                other_errs++;
                $display("Unexpected output at %0t while no result was expected", $time);
            end else begin
                check_value(score, exp_score.pop_front(), "score");
                check_value(v_out, exp_v.pop_front(), "v_out");
            end
        end
    end

    always @(posedge clk) begin
        if (bp_en) rdy_in <= ((lcg_next() >> 31) & 1) == 1; // About half the cycles
        else       rdy_in <= 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results still outstanding",
                     cycles, exp_score.size());
            $display("Summary: %0d outputs, %0d checks, %0d value errors, %0d other failures",
                     outputs, checks, value_errs, other_errs + 1);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        start   = 1'b0;
        q_base  = '0;
        k_base  = '0;
        v_base  = '0;
        num_q   = '0;
        rdy_in  = 1'b1;

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0) check_value(vld_out, 0, "vld_out in reset"); // First edge is pre-reset
        end
        rst <= 1'b0;

        // Idle after reset, nothing may come out
        repeat (5) begin
            @(posedge clk);
            check_value(vld_out, 0, "vld_out before start");
        end

        // Random fill, then fixed rows for the saturation case
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            write_word(attn_mem_pkg::addr_t'(a), random_vector());
        end
        write_word(6'd16, {`EMBED_DIM{8'h80}}); // Q all -128
        write_word(6'd17, {`EMBED_DIM{8'h80}}); // K all -128
        write_word(6'd18, {`EMBED_DIM{8'h7f}}); // K all 127
        end_writes();

        // Random vectors, two queries, no back-pressure
        run_queries(6'd0, 6'd8, 6'd12, 2);
        wait_drain();

        // Saturation and the largest in-range negative score
        check_value(ref_score(shadow[16], shadow[17]), 32767, "positive clamp reference");
        check_value(ref_score(shadow[16], shadow[18]), -32512, "negative score reference");
        run_queries(6'd16, 6'd17, 6'd24, 1);
        wait_drain();

        // Full query count with random back-pressure
        bp_en = 1'b1;
        run_queries(6'd32, 6'd40, 6'd44, `MAX_Q);
        wait_drain();
        bp_en = 1'b0;

        // Fresh bases and count after the previous run drained
        run_queries(6'd48, 6'd52, 6'd56, 3);
        wait_drain();

        if (exp_score.size() != 0) begin
            other_errs++;
            $display("%0d expected results never came out", exp_score.size());
        end

        $display("Summary: %0d outputs, %0d checks, %0d value errors, %0d other failures",
                 outputs, checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
